//--- Makefile
# Verilator build and run of the timer/counter testbench

VERILATOR ?= verilator
TOP       ?= timerCounterTb
FILELIST  ?= timerCounter.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(BUILD_DIR)

//--- timerCounter.f
timerCounterPkg.sv
tmrBusDecode.sv
tmrPrescaler.sv
tmrWaveGen.sv
tmrChannel.sv
tmrReadMux.sv
timerCounter.sv
timerCounterTb.sv

//--- timerCounter.sv
// Timer/counter peripheral top level
// Bus decoder, shared prescaler, the timer channels and the read mux

`timescale 1ns/10ps
`default_nettype none

module timerCounter
(
   input  wire logic                                cp2,
   input  wire logic                                ireset,
   input  wire logic [timerCounterPkg::adrW-1:0]    adr,
   input  wire logic [timerCounterPkg::dataW-1:0]   dbusIn,
   input  wire logic                                iowe,
   input  wire logic                                iore,
   output wire logic [timerCounterPkg::dataW-1:0]   dbusOut,
   output wire logic                                outEn,
   input  wire logic [timerCounterPkg::numChan-1:0] ovfAck,
   input  wire logic [timerCounterPkg::numChan-1:0] cmpAck,
   output wire logic [timerCounterPkg::numChan-1:0] ovfIrq,
   output wire logic [timerCounterPkg::numChan-1:0] cmpIrq,
   output wire logic [timerCounterPkg::numChan-1:0] oc
);
   import timerCounterPkg::*;

   chanWrT           chanWr [numChan];
   chanStatT         stat   [numChan];
   prescTicksT       ticks;
   logic [dataW-1:0] timsk;

   tmrBusDecode iBusDecode
   (
      .cp2    (cp2),
      .ireset (ireset),
      .adr    (adr),
      .dbusIn (dbusIn),
      .iowe   (iowe),
      .ovfAck (ovfAck),
      .cmpAck (cmpAck),
      .chanWr (chanWr),
      .timsk  (timsk)
   );

   tmrPrescaler iPrescaler
   (
      .cp2    (cp2),
      .ireset (ireset),
      .ticks  (ticks)
   );

   // ------------------------------------------------------------------
   // Timer channels, slot 0 is T/C0 and slot 1 is T/C2
   // ------------------------------------------------------------------
   for (genvar i = 0; i < numChan; i++)
   begin : gChan
      tmrChannel iChannel
      (
         .cp2    (cp2),
         .ireset (ireset),
         .wr     (chanWr[i]),
         .ticks  (ticks),
         .stat   (stat[i]),
         .oc     (oc[i])
      );
   end

   tmrReadMux iReadMux
   (
      .adr     (adr),
      .iore    (iore),
      .stat    (stat),
      .timsk   (timsk),
      .dbusOut (dbusOut),
      .outEn   (outEn),
      .ovfIrq  (ovfIrq),
      .cmpIrq  (cmpIrq)
   );

endmodule

`default_nettype wire

//--- timerCounterPkg.sv
// Timer/counter shared definitions
// Register map, flag positions and the structs passed between the blocks

`default_nettype none

package timerCounterPkg;

   localparam int dataW   = 8;         // Bus and register width
   localparam int adrW    = 6;         // I/O address width
   localparam int preW    = 10;        // Prescaler counter width
   localparam int numChan = 2;         // Channel 0 and channel 2

   // ------------------------------------------------------------------
   // I/O register map
   // ------------------------------------------------------------------
   localparam logic [adrW-1:0] timskAdr = 6'h39;
   localparam logic [adrW-1:0] tifrAdr  = 6'h38;

   // Indexed by channel slot
   localparam logic [adrW-1:0] tccrAdr [numChan] = '{6'h33, 6'h25};
   localparam logic [adrW-1:0] tcntAdr [numChan] = '{6'h32, 6'h24};
   localparam logic [adrW-1:0] ocrAdr  [numChan] = '{6'h31, 6'h23};

   // Bit positions in TIFR and TIMSK
   localparam int tovBit [numChan] = '{0, 6};
   localparam int ocfBit [numChan] = '{1, 7};

   // Compare-output modes
   localparam logic [1:0] comToggle = 2'b01;
   localparam logic [1:0] comClear  = 2'b10;
   localparam logic [1:0] comSet    = 2'b11;

   // ------------------------------------------------------------------
   // Shared types
   // ------------------------------------------------------------------
   typedef struct packed {
      logic       rsvd;                // Always reads 0
      logic       pwm;
      logic [1:0] com;
      logic       ctc;
      logic [2:0] cs;
   } tccrT;

   typedef struct packed {
      logic t8;
      logic t32;
      logic t64;
      logic t128;
      logic t256;
      logic t1024;
   } prescTicksT;

   typedef struct packed {
      logic             tccrWr;
      logic             tcntWr;
      logic             ocrWr;
      logic             tovClr;        // Write of 1 to TIFR
      logic             ocfClr;
      logic             tovAck;        // Interrupt acknowledge
      logic             ocfAck;
      logic [dataW-1:0] data;
   } chanWrT;

   typedef struct packed {
      tccrT             tccr;
      logic [dataW-1:0] tcnt;
      logic [dataW-1:0] ocrView;       // Buffer in PWM mode
      logic             tov;
      logic             ocf;
   } chanStatT;

endpackage

`default_nettype wire

//--- timerCounterTb.sv
// Timer/counter testbench
// Table-driven checks of readback, overflow, CTC, PWM, prescaler and channel independence

`timescale 1ns/10ps
`default_nettype none

module timerCounterTb;
   import timerCounterPkg::*;

   typedef enum {kReadback, kOverflow, kCtc, kPwm, kPresc, kIndep} testKindT;

   typedef struct {
      string      name;
      testKindT   kind;
      int         slot;
      logic [7:0] tccr;
      logic [7:0] tcnt;                  // Start count, old OCR in PWM tests
      logic [7:0] ocr;
      int         waitCyc;
      int         expVal;
      int         tol;
   } testEntryT;

   logic               cp2;
   logic               ireset;
   logic [adrW-1:0]    adr;
   logic [dataW-1:0]   dbusIn;
   logic               iowe;
   logic               iore;
   logic [dataW-1:0]   dbusOut;
   logic               outEn;
   logic [numChan-1:0] ovfAck;
   logic [numChan-1:0] cmpAck;
   logic [numChan-1:0] ovfIrq;
   logic [numChan-1:0] cmpIrq;
   logic [numChan-1:0] oc;

   testEntryT   tests[$];
   logic [31:0] rngState   = 32'h2397_dc06;
   int          errorCount = 0;
   bit          tableReady = 1'b0;

   initial cp2 = 1'b0;
   always #4 cp2 = ~cp2;                 // 8 ns period

   timerCounter i_timerCounter
   (
      .cp2     (cp2),
      .ireset  (ireset),
      .adr     (adr),
      .dbusIn  (dbusIn),
      .iowe    (iowe),
      .iore    (iore),
      .dbusOut (dbusOut),
      .outEn   (outEn),
      .ovfAck  (ovfAck),
      .cmpAck  (cmpAck),
      .ovfIrq  (ovfIrq),
      .cmpIrq  (cmpIrq),
      .oc      (oc)
   );

   // ------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------
   function logic [7:0] randByte();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState[23:16];            // Upper bits, better spread
   endfunction

   task automatic addTest(input string name, input testKindT kind, input int slot,
                          input logic [7:0] tccr, input logic [7:0] tcnt,
                          input logic [7:0] ocr, input int waitCyc, input int expVal,
                          input int tol);
      tests.push_back(testEntryT'{name, kind, slot, tccr, tcnt, ocr, waitCyc, expVal, tol});
   endtask

   task automatic failValue(input string name, input int expected, input int actual);
      errorCount++;
      $display("error %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic failText(input string what);
      errorCount++;
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic checkEq(input string name, input int expected, input int actual,
                          input int tol);
      int diff;
      diff = (expected > actual) ? expected - actual : actual - expected;
      assert (diff <= tol)
         else failValue(name, expected, actual);
   endtask

   // Bus tasks start and end on a falling edge
   task automatic writeReg(input logic [adrW-1:0] a, input logic [7:0] d);
      adr    = a;
      dbusIn = d;
      iowe   = 1'b1;
      @(negedge cp2);
      iowe   = 1'b0;
   endtask

   task automatic readReg(input logic [adrW-1:0] a, output logic [7:0] d, output logic en);
      adr  = a;
      iore = 1'b1;
      #1;                                // Let the read mux settle
      d    = dbusOut;
      en   = outEn;
      @(negedge cp2);
      iore = 1'b0;
   endtask

   task automatic readCheck(input string name, input logic [adrW-1:0] a,
                            input logic [7:0] expected);
      logic [7:0] d;
      logic       en;
      readReg(a, d, en);
      checkEq({name, " outEn"}, 1, int'(en), 0);
      checkEq(name, int'(expected), int'(d), 0);
   endtask

   task automatic applyReset();
      ireset = 1'b0;
      repeat (4) @(negedge cp2);
      ireset = 1'b1;
   endtask

   // Cycles from the last write edge until the TIFR bit reads 1
   task automatic pollFlag(input int bitPos, input int limit, output int cycles);
      logic [7:0] d;
      logic       en;
      bit         found;
      cycles = 0;
      found  = 1'b0;
      while (!found && cycles <= limit)
      begin
         readReg(tifrAdr, d, en);
         if (d[bitPos])
            found = 1'b1;
         else
            cycles++;
      end
      assert (found)
         else failText("A timer flag never set within its time limit");
   endtask

   // ------------------------------------------------------------------
   // Test kinds
   // ------------------------------------------------------------------
   task automatic runReadback(input testEntryT e);
      logic [7:0] d;
      logic       en;
      writeReg(tccrAdr[e.slot], e.tccr);   // cs=000, counter stopped
      writeReg(tcntAdr[e.slot], e.tcnt);
      writeReg(ocrAdr[e.slot], e.ocr);
      writeReg(timskAdr, 8'(e.expVal));
      writeReg(tifrAdr, 8'hFF);
      readCheck({e.name, " tccr"}, tccrAdr[e.slot], e.tccr);
      readCheck({e.name, " tcnt"}, tcntAdr[e.slot], e.tcnt);
      readCheck({e.name, " ocr"}, ocrAdr[e.slot], e.ocr);
      readCheck({e.name, " timsk"}, timskAdr, 8'(e.expVal));
      readCheck({e.name, " tifr"}, tifrAdr, 8'h00);
      readReg(6'h00, d, en);
      checkEq({e.name, " unmapped outEn"}, 0, int'(en), 0);
   endtask

   task automatic runOverflow(input testEntryT e);
      logic [7:0] d;
      logic       en;
      int         cyc;
      int         tb;
      tb = tovBit[e.slot];
      writeReg(tcntAdr[e.slot], e.tcnt);
      writeReg(tccrAdr[e.slot], e.tccr);
      pollFlag(tb, e.waitCyc / 2, cyc);
      checkEq({e.name, " cycles to tov"}, e.expVal, cyc, 0);
      checkEq({e.name, " irq masked"}, 0, int'(ovfIrq[e.slot]), 0);
      writeReg(timskAdr, 8'(1 << tb));
      checkEq({e.name, " irq enabled"}, 1, int'(ovfIrq[e.slot]), 0);
      writeReg(tifrAdr, 8'(1 << tb));      // Write 1 to clear
      readReg(tifrAdr, d, en);
      checkEq({e.name, " tov after clear"}, 0, int'(d[tb]), 0);
      checkEq({e.name, " irq after clear"}, 0, int'(ovfIrq[e.slot]), 0);
      writeReg(tcntAdr[e.slot], e.tcnt);
      pollFlag(tb, e.waitCyc / 2, cyc);
      checkEq({e.name, " cycles to second tov"}, e.expVal, cyc, 0);
      ovfAck[e.slot] = 1'b1;
      @(negedge cp2);
      ovfAck[e.slot] = 1'b0;
      readReg(tifrAdr, d, en);
      checkEq({e.name, " tov after ack"}, 0, int'(d[tb]), 0);
      checkEq({e.name, " irq after ack"}, 0, int'(ovfIrq[e.slot]), 0);
   endtask

   task automatic runCtc(input testEntryT e);
      logic [7:0] d;
      logic       en;
      logic       prevOc;
      int         toggles;
      int         lastEdge;
      int         maxCnt;
      writeReg(ocrAdr[e.slot], e.ocr);
      writeReg(tccrAdr[e.slot], e.tccr);
      prevOc   = oc[e.slot];
      toggles  = 0;
      lastEdge = 0;
      maxCnt   = 0;
      for (int c = 0; c < e.waitCyc; c++)
      begin
         if (oc[e.slot] != prevOc)
         begin
            if (toggles > 0)
               checkEq({e.name, " toggle period"}, e.expVal, c - lastEdge, 0);
            lastEdge = c;
            toggles++;
            prevOc = oc[e.slot];
         end
         readReg(tcntAdr[e.slot], d, en);   // One sample per cycle
         if (int'(d) > maxCnt)
            maxCnt = int'(d);
      end
      assert (toggles >= 2)
         else failText({e.name, ": the compare pin did not toggle twice"});
      checkEq({e.name, " highest tcnt"}, int'(e.ocr), maxCnt, 0);
      readReg(tifrAdr, d, en);
      checkEq({e.name, " ocf"}, 1, int'(d[ocfBit[e.slot]]), 0);
   endtask

   task automatic runPwm(input testEntryT e);
      logic [7:0] d;
      logic       en;
      logic       prevOc;
      int         c;
      int         lowCnt;
      int         edges;
      writeReg(ocrAdr[e.slot], e.tcnt);    // Old duty, direct while not in PWM
      writeReg(tccrAdr[e.slot], e.tccr);
      writeReg(ocrAdr[e.slot], e.ocr);     // Goes to the buffer
      readReg(ocrAdr[e.slot], d, en);
      checkEq({e.name, " buffered ocr"}, int'(e.ocr), int'(d), 0);
      if (e.tccr[5:4] == comClear)
      begin
         c = 0;
         while (!oc[e.slot] && c < 300)
         begin
            @(negedge cp2);
            c++;
         end
         assert (oc[e.slot])
            else failText({e.name, ": the compare pin never rose on the old duty"});
         readReg(tcntAdr[e.slot], d, en);
         checkEq({e.name, " rise on old ocr"}, int'(e.tcnt) + 1, int'(d), 0);
      end
      repeat (400) @(negedge cp2);         // Past the top, new duty active
      lowCnt = 0;
      edges  = 0;
      prevOc = oc[e.slot];
      for (int i = 0; i < 510; i++)
      begin
         if (!oc[e.slot])
            lowCnt++;
         if (oc[e.slot] != prevOc)
            edges++;
         prevOc = oc[e.slot];
         @(negedge cp2);
      end
      checkEq({e.name, " low cycles"}, e.expVal, lowCnt, e.tol);
      if (e.ocr == 8'h00 || e.ocr == 8'hFF)
         checkEq({e.name, " pin edges"}, 0, edges, 0);
   endtask

   task automatic runPresc(input testEntryT e);
      logic [7:0] d;
      logic       en;
      int         first;
      writeReg(tccrAdr[e.slot], e.tccr);
      readReg(tcntAdr[e.slot], d, en);
      first = int'(d);
      repeat (e.waitCyc - 1) @(negedge cp2);
      readReg(tcntAdr[e.slot], d, en);
      checkEq({e.name, " tcnt advance"}, e.expVal, int'(d) - first, e.tol);
   endtask

   // Slot runs CTC toggle, the other slot runs normal mode towards overflow
   task automatic runIndep(input testEntryT e);
      logic [7:0] allMask;
      logic       prevOc;
      int         o;
      int         toggles;
      int         lastEdge;
      o       = 1 - e.slot;
      allMask = 8'((1 << tovBit[0]) | (1 << ocfBit[0]) | (1 << tovBit[1]) | (1 << ocfBit[1]));
      writeReg(ocrAdr[e.slot], e.ocr);
      writeReg(tcntAdr[o], e.tcnt);
      writeReg(ocrAdr[o], 8'h80);          // Not reached in the window
      writeReg(timskAdr, allMask);
      writeReg(tccrAdr[o], 8'h01);
      writeReg(tccrAdr[e.slot], e.tccr);
      prevOc   = oc[e.slot];
      toggles  = 0;
      lastEdge = 0;
      for (int c = 0; c < e.waitCyc; c++)
      begin
         if (oc[e.slot] != prevOc)
         begin
            if (toggles > 0)
               checkEq({e.name, " toggle period"}, e.expVal, c - lastEdge, 0);
            lastEdge = c;
            toggles++;
            prevOc = oc[e.slot];
         end
         checkEq({e.name, " other pin"}, 0, int'(oc[o]), 0);
         checkEq({e.name, " own ovfIrq"}, 0, int'(ovfIrq[e.slot]), 0);
         checkEq({e.name, " other cmpIrq"}, 0, int'(cmpIrq[o]), 0);
         @(negedge cp2);
      end
      assert (toggles >= 2)
         else failText({e.name, ": the compare pin did not toggle twice"});
      checkEq({e.name, " other ovfIrq"}, 1, int'(ovfIrq[o]), 0);
      checkEq({e.name, " own cmpIrq"}, 1, int'(cmpIrq[e.slot]), 0);
   endtask

   // ------------------------------------------------------------------
   // Stimulus table
   // ------------------------------------------------------------------
   task automatic buildTable();
      logic [7:0] r;
      int         n;
      addTest("readback slot0", kReadback, 0, 8'h38, 8'h5A, randByte(), 20, 'hC3, 0);
      addTest("readback slot1", kReadback, 1, 8'h28, 8'hA5, randByte(), 20, 'h41, 0);
      addTest("overflow slot0", kOverflow, 0, 8'h01, 8'hF0, 8'h00, 100, 256 - 'hF0, 0);
      addTest("overflow slot1", kOverflow, 1, 8'h01, 8'hE8, 8'h00, 100, 256 - 'hE8, 0);
      n = 3 + int'(randByte()) % 13;
      addTest("ctc slot0", kCtc, 0, 8'h19, 8'h00, 8'(n), 4 * (n + 1) + 4, n + 1, 0);
      n = 3 + int'(randByte()) % 13;
      addTest("ctc slot1", kCtc, 1, 8'h19, 8'h00, 8'(n), 4 * (n + 1) + 4, n + 1, 0);
      addTest("pwm slot0", kPwm, 0, 8'h61, 8'h30, 8'h50, 1220, 2 * 'h50, 2);
      addTest("pwm inverted slot1", kPwm, 1, 8'h71, 8'h30, 8'h40, 1220, 510 - 2 * 'h40, 2);
      addTest("pwm zero slot0", kPwm, 0, 8'h61, 8'h30, 8'h00, 1220, 0, 2);
      addTest("pwm full slot1", kPwm, 1, 8'h61, 8'h30, 8'hFF, 1220, 510, 2);
      r = randByte();
      addTest("pwm random slot1", kPwm, 1, 8'h61, 8'h30, r, 1220, 2 * int'(r), 2);
      addTest("prescaler slot0", kPresc, 0, 8'h02, 8'h00, 8'h00, 80, 80 / 8, 1);
      addTest("prescaler slot1", kPresc, 1, 8'h02, 8'h00, 8'h00, 80, 80 / 8, 1);
      n = 3 + int'(randByte()) % 13;
      addTest("independent slot0", kIndep, 0, 8'h19, 8'hF0, 8'(n), 60, n + 1, 0);
      n = 3 + int'(randByte()) % 13;
      addTest("independent slot1", kIndep, 1, 8'h19, 8'hF0, 8'(n), 60, n + 1, 0);
   endtask

   initial
   begin
      ireset = 1'b0;
      adr    = '0;
      dbusIn = '0;
      iowe   = 1'b0;
      iore   = 1'b0;
      ovfAck = '0;
      cmpAck = '0;
      buildTable();
      tableReady = 1'b1;
      @(negedge cp2);
      foreach (tests[i])
      begin
         applyReset();                   // Fresh state per entry
         case (tests[i].kind)
            kReadback: runReadback(tests[i]);
            kOverflow: runOverflow(tests[i]);
            kCtc:      runCtc(tests[i]);
            kPwm:      runPwm(tests[i]);
            kPresc:    runPresc(tests[i]);
            kIndep:    runIndep(tests[i]);
         endcase
         $display("done %s", tests[i].name);
      end
      if (errorCount == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // Watchdog sized from the table
   initial
   begin
      int limit;
      wait (tableReady);
      limit = 1000;
      foreach (tests[i])
         limit += tests[i].waitCyc + 100;
      repeat (limit) @(posedge cp2);
      $display("Timeout: the tests were still running after %0d cycles", limit);
      $display("Some tests failed");
      $fatal(1, "Watchdog expired");
   end

endmodule

`default_nettype wire

//--- tmrBusDecode.sv
// Timer bus write decoder
// Turns iowe strobes into per-channel write commands and holds TIMSK

`timescale 1ns/10ps
`default_nettype none

module tmrBusDecode
(
   input  wire logic                                cp2,
   input  wire logic                                ireset,
   input  wire logic [timerCounterPkg::adrW-1:0]    adr,
   input  wire logic [timerCounterPkg::dataW-1:0]   dbusIn,
   input  wire logic                                iowe,
   input  wire logic [timerCounterPkg::numChan-1:0] ovfAck,
   input  wire logic [timerCounterPkg::numChan-1:0] cmpAck,
   output timerCounterPkg::chanWrT                  chanWr [timerCounterPkg::numChan],
   output logic [timerCounterPkg::dataW-1:0]        timsk
);
   import timerCounterPkg::*;

   logic tifrWr;
   logic timskWr;

   assign tifrWr  = iowe && (adr == tifrAdr);
   assign timskWr = iowe && (adr == timskAdr);

   always_comb
   begin
      for (int i = 0; i < numChan; i++)
      begin
         chanWr[i].tccrWr = iowe && (adr == tccrAdr[i]);
         chanWr[i].tcntWr = iowe && (adr == tcntAdr[i]);
         chanWr[i].ocrWr  = iowe && (adr == ocrAdr[i]);
         chanWr[i].tovClr = tifrWr && dbusIn[tovBit[i]];   // Write 1 to clear
         chanWr[i].ocfClr = tifrWr && dbusIn[ocfBit[i]];
         chanWr[i].tovAck = ovfAck[i];
         chanWr[i].ocfAck = cmpAck[i];
         chanWr[i].data   = dbusIn;
      end
   end

   // Interrupt mask register
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         timsk <= '0;
      else if (timskWr)
         timsk <= dbusIn;
   end

endmodule

`default_nettype wire

//--- tmrChannel.sv
// One 8-bit timer/counter channel
// Control, counter, buffered compare, PWM direction, compare block and flags

`timescale 1ns/10ps
`default_nettype none

module tmrChannel
(
   input  wire logic                        cp2,
   input  wire logic                        ireset,
   input  wire timerCounterPkg::chanWrT     wr,
   input  wire timerCounterPkg::prescTicksT ticks,
   output timerCounterPkg::chanStatT        stat,
   output wire logic                        oc
);
   import timerCounterPkg::*;

   tccrT             tccr;
   logic [dataW-1:0] tcnt;
   logic [dataW-1:0] ocr;
   logic [dataW-1:0] ocrBuf;             // PWM double buffer
   logic             down;               // PWM count direction
   logic             wrBlk;              // TCNT written, waiting for a tick
   logic             tov;
   logic             ocf;
   logic             tick;
   logic             atTop;
   logic             atBottom;
   logic             cmpEq;
   logic             blocked;
   logic             ocMatch;

   always_comb
   begin
      case (tccr.cs)
         3'b001:  tick = 1'b1;
         3'b010:  tick = ticks.t8;
         3'b011:  tick = ticks.t32;
         3'b100:  tick = ticks.t64;
         3'b101:  tick = ticks.t128;
         3'b110:  tick = ticks.t256;
         3'b111:  tick = ticks.t1024;
         default: tick = 1'b0;           // Stopped
      endcase
   end

   assign atTop    = (tcnt == '1);
   assign atBottom = (tcnt == '0);
   assign cmpEq    = (tcnt == ocr);
   assign blocked  = wrBlk || wr.tcntWr;
   assign ocMatch  = cmpEq && !(tccr.pwm && ocr == '0);

   // ------------------------------------------------------------------
   // Control, counter and direction
   // ------------------------------------------------------------------
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         tccr <= '0;
      else if (wr.tccrWr)
         tccr <= tccrT'({1'b0, wr.data[dataW-2:0]});
   end

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         tcnt <= '0;
      else if (wr.tcntWr)
         tcnt <= wr.data;
      else if (tick)
      begin
         if (!tccr.pwm)
            tcnt <= (tccr.ctc && cmpEq) ? '0 : tcnt + 1'b1;   // CTC clear
         else if (!down)
            tcnt <= atTop ? tcnt - 1'b1 : tcnt + 1'b1;
         else
            tcnt <= atBottom ? tcnt + 1'b1 : tcnt - 1'b1;
      end
   end

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         down <= 1'b0;
      else if (tick && tccr.pwm && !wr.tcntWr)
      begin
         if (!down && atTop)
            down <= 1'b1;
         else if (down && atBottom)
            down <= 1'b0;
      end
   end

   // ------------------------------------------------------------------
   // Compare register and write block
   // ------------------------------------------------------------------
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         ocr    <= '0;
         ocrBuf <= '0;
      end
      else
      begin
         if (wr.ocrWr)
            ocrBuf <= wr.data;
         if (!tccr.pwm)
         begin
            if (wr.ocrWr)
               ocr <= wr.data;
         end
         else if (tick && atTop)
            ocr <= ocrBuf;               // Update at the top
      end
   end

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         wrBlk <= 1'b0;
      else if (wr.tcntWr)
         wrBlk <= !tick;
      else if (tick)
         wrBlk <= 1'b0;
   end

   // Flags. A clear only acts on a flag that is already set
   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         tov <= 1'b0;
         ocf <= 1'b0;
      end
      else
      begin
         if (!tov)
         begin
            if (tick && (tccr.pwm ? atBottom : atTop))
               tov <= 1'b1;
         end
         else if (wr.tovClr || wr.tovAck)
            tov <= 1'b0;
         if (!ocf)
         begin
            if (tick && cmpEq && !blocked)
               ocf <= 1'b1;
         end
         else if (wr.ocfClr || wr.ocfAck)
            ocf <= 1'b0;
      end
   end

   tmrWaveGen iWaveGen
   (
      .cp2     (cp2),
      .ireset  (ireset),
      .tick    (tick),
      .pwm     (tccr.pwm),
      .up      (!down),
      .atTop   (atTop),
      .match   (ocMatch),
      .blocked (blocked),
      .com     (tccr.com),
      .ocrBuf  (ocrBuf),
      .oc      (oc)
   );

   always_comb
   begin
      stat.tccr    = tccr;
      stat.tcnt    = tcnt;
      stat.ocrView = tccr.pwm ? ocrBuf : ocr;
      stat.tov     = tov;
      stat.ocf     = ocf;
   end

   // The count turns at 0xFF, so a down step never lands there
   assert property (@(posedge cp2) disable iff (!ireset)
                    tccr.pwm && tick && down && !wr.tcntWr |=> tcnt != '1)
      else $error("PWM counter reached 0xFF while counting down");

endmodule

`default_nettype wire

//--- tmrPrescaler.sv
// Shared clock prescaler
// Free-running counter with one-cycle tick pulses at /8 up to /1024

`timescale 1ns/10ps
`default_nettype none

module tmrPrescaler
(
   input  wire logic                   cp2,
   input  wire logic                   ireset,
   output timerCounterPkg::prescTicksT ticks
);
   import timerCounterPkg::*;

   logic [preW-1:0] preCnt;

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
      begin
         preCnt <= '0;
         ticks  <= '0;
      end
      else
      begin
         preCnt      <= preCnt + 1'b1;
         ticks.t8    <= &preCnt[2:0];      // Low bits all ones
         ticks.t32   <= &preCnt[4:0];
         ticks.t64   <= &preCnt[5:0];
         ticks.t128  <= &preCnt[6:0];
         ticks.t256  <= &preCnt[7:0];
         ticks.t1024 <= &preCnt[preW-1:0];
      end
   end

   assert property (@(posedge cp2) disable iff (!ireset) ticks.t8 |=> !ticks.t8)
      else $error("t8 tick held for two cycles");

endmodule

`default_nettype wire

//--- tmrReadMux.sv
// Timer read-back multiplexer
// Builds TIFR, selects read data by address and gates flags into IRQs

`timescale 1ns/10ps
`default_nettype none

module tmrReadMux
(
   input  wire logic [timerCounterPkg::adrW-1:0]  adr,
   input  wire logic                              iore,
   input  wire timerCounterPkg::chanStatT         stat [timerCounterPkg::numChan],
   input  wire logic [timerCounterPkg::dataW-1:0] timsk,
   output logic [timerCounterPkg::dataW-1:0]      dbusOut,
   output logic                                   outEn,
   output logic [timerCounterPkg::numChan-1:0]    ovfIrq,
   output logic [timerCounterPkg::numChan-1:0]    cmpIrq
);
   import timerCounterPkg::*;

   logic [dataW-1:0] tifr;
   logic             mapped;

   always_comb
   begin
      tifr = '0;                         // Unused bits read 0
      for (int i = 0; i < numChan; i++)
      begin
         tifr[tovBit[i]] = stat[i].tov;
         tifr[ocfBit[i]] = stat[i].ocf;
         ovfIrq[i]       = stat[i].tov & timsk[tovBit[i]];
         cmpIrq[i]       = stat[i].ocf & timsk[ocfBit[i]];
      end
   end

   always_comb
   begin
      dbusOut = '0;
      mapped  = 1'b0;
      if (adr == timskAdr)
      begin
         dbusOut = timsk;
         mapped  = 1'b1;
      end
      else if (adr == tifrAdr)
      begin
         dbusOut = tifr;
         mapped  = 1'b1;
      end
      for (int i = 0; i < numChan; i++)
      begin
         if (adr == tccrAdr[i])
         begin
            dbusOut = stat[i].tccr;
            mapped  = 1'b1;
         end
         else if (adr == tcntAdr[i])
         begin
            dbusOut = stat[i].tcnt;
            mapped  = 1'b1;
         end
         else if (adr == ocrAdr[i])
         begin
            dbusOut = stat[i].ocrView;
            mapped  = 1'b1;
         end
      end
   end

   assign outEn = iore && mapped;

endmodule

`default_nettype wire

//--- tmrWaveGen.sv
// Compare-output waveform generator
// Toggles the pin in non-PWM mode, sets or clears it in phase-correct PWM

`timescale 1ns/10ps
`default_nettype none

module tmrWaveGen
(
   input  wire logic                              cp2,
   input  wire logic                              ireset,
   input  wire logic                              tick,
   input  wire logic                              pwm,
   input  wire logic                              up,
   input  wire logic                              atTop,
   input  wire logic                              match,
   input  wire logic                              blocked,
   input  wire logic [1:0]                        com,
   input  wire logic [timerCounterPkg::dataW-1:0] ocrBuf,
   output logic                                   oc
);
   import timerCounterPkg::*;

   logic hit;
   logic inv;

   assign hit = match && !blocked;
   assign inv = (com == comSet);       // Inverted PWM

   always_ff @(posedge cp2 or negedge ireset)
   begin
      if (!ireset)
         oc <= 1'b0;
      else if (tick)
      begin
         if (!pwm)
         begin
            if (hit && com == comToggle)
               oc <= ~oc;
         end
         else if (com == comClear || com == comSet)
         begin
            // Buffer end values give a constant pin
            if (atTop)
            begin
               if (ocrBuf == '0)
                  oc <= ~inv;
               else if (ocrBuf == '1)
                  oc <= inv;
            end
            else if (hit)
               oc <= up ^ inv;           // Set going up, clear going down
         end
      end
   end

endmodule

`default_nettype wire
